// ==== build.f ====
src/soc_ctrl_pkg.sv
src/rx_byte_if.sv
src/spi_byte_slave.sv
src/srl_byte_fifo.sv
src/soc_cmd_engine.sv
src/soc_ctrl_top.sv
tb/soc_ctrl_properties.sv
tb/tb_soc_ctrl.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the testbench with Verilator, runs it and checks the result line
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ns \
    --top-module tb_soc_ctrl -f build.f

out=$(./obj_dir/Vtb_soc_ctrl +verilator+error+limit+1000 2>&1) || {
    echo "$out"
    exit 1
}
echo "$out"
echo "$out" | grep -q "Simulation passed"

// ==== tb/spi_stimulus.txt ====
# kind opcode addr count data...  (opcode, addr and data in hex, count in decimal)
# W and X lines carry count data bytes, R lines send count random dummy bytes
X 55 000 4 11 22 33 44
W B0 010 8 01 02 03 04 05 06 07 08
R A0 010 8
R A0 013 5
W B0 3FE 6 A1 A2 A3 A4 A5 A6
R A0 000 4
R A0 3FE 6
X C3 010 4 EE EE EE EE
R A0 010 4
X A1 3FE 3 99 98 97
R A0 3FE 2
W B0 100 0
W B0 200 3 5A 5B 5C
R A0 200 3
R A0 012 3
W B0 011 2 F0 F1
R A0 010 8

// ==== tb/tb_soc_ctrl.sv ====
// testbench for the SPI register control path; replays the frames of the stimulus file
`default_nettype none
`timescale 1ns/1ns

module tb_soc_ctrl import soc_ctrl_pkg::*; ();

    localparam int HALF_MIN   = 4;
    localparam int HALF_MAX   = 6;
    localparam int CS_GAP     = 8;
    localparam int RST_CYCLES = 4;
    localparam int RAM_SIZE   = 1024;

    logic clk_250mhz = 1'b0;
    logic rst_i;
    logic spi_cs_i;
    logic spi_sck_i;
    logic spi_mosi_i;
    logic spi_miso_o;

    // one entry per frame, W and X data bytes in file order
    logic [7:0] kind_q [$];
    logic [7:0] op_q [$];
    logic [9:0] addr_q [$];
    int         cnt_q [$];
    logic [7:0] data_q [$];

    // expected register contents
    logic [7:0] shadow [RAM_SIZE];
    logic       written [RAM_SIZE];

    int          value_errs  = 0;
    int          other_errs  = 0;
    int unsigned cycles      = 0;
    int unsigned cycle_limit = 100000;

    soc_ctrl_top #(
        .FIFO_DEPTH  (DEF_FIFO_DEPTH),
        .SYNC_STAGES (DEF_SYNC_STAGES)
    ) dut_i (
        .clk_250mhz (clk_250mhz),
        .rst_i      (rst_i),
        .spi_cs_i   (spi_cs_i),
        .spi_sck_i  (spi_sck_i),
        .spi_mosi_i (spi_mosi_i),
        .spi_miso_o (spi_miso_o)
    );

    always #2 clk_250mhz = ~clk_250mhz;

    always @(posedge clk_250mhz) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout: the run did not finish within %0d clock cycles", cycle_limit);
            $display("Simulation failed");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////
    // stimulus file and SPI host
    ////////////////////////////////////////////////////////////

    // inputs change a small offset after the rising edge
    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk_250mhz);
        #1;
    endtask

    task automatic load_stimulus();
        int               fd;
        int               code;
        int               cnt;
        logic [7:0]       kind;
        logic [7:0]       op;
        logic [9:0]       addr;
        logic [7:0]       d;
        logic [8*256-1:0] skip;
        fd = $fopen("tb/spi_stimulus.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file tb/spi_stimulus.txt");
            other_errs++;
            return;
        end
        while (!$feof(fd)) begin
            code = $fscanf(fd, " %c", kind);
            if (code != 1) begin
                break;
            end
            if (kind == "#") begin
                code = $fgets(skip, fd);
            end else begin
                code = $fscanf(fd, "%h %h %d", op, addr, cnt);
                if (code != 3 || cnt < 0 || (kind != "W" && kind != "R" && kind != "X")) begin
                    $display("the stimulus file holds a frame line that cannot be parsed");
                    other_errs++;
                    break;
                end
                kind_q.push_back(kind);
                op_q.push_back(op);
                addr_q.push_back(addr);
                cnt_q.push_back(cnt);
                for (int i = 0; i < cnt && kind != "R"; i++) begin
                    code = $fscanf(fd, "%h", d);
                    if (code != 1) begin
                        $display("a frame line in the stimulus file lacks data bytes");
                        other_errs++;
                        break;
                    end
                    data_q.push_back(d);
                end
            end
        end
        $fclose(fd);
    endtask

    // mode 0, msb first; miso sampled just before each rising sck
    task automatic shift_byte(input logic [7:0] tx, input int half, output logic [7:0] rx);
        for (int b = 7; b >= 0; b--) begin
            spi_mosi_i = tx[b];
            wait_cycles(half);
            rx[b] = spi_miso_o;
            spi_sck_i = 1'b1;
            wait_cycles(half);
            spi_sck_i = 1'b0;
        end
    endtask

    task automatic run_frame(input int f);
        logic [7:0] op;
        logic [9:0] addr;
        logic [9:0] a;
        logic [7:0] tx;
        logic [7:0] rx;
        logic [7:0] exp;
        logic       check;
        int         half;
        op   = op_q[f];
        addr = addr_q[f];
        half = int'($urandom_range(HALF_MAX, HALF_MIN));
        spi_cs_i = 1'b0;
        for (int i = 0; i < 3 + cnt_q[f]; i++) begin
            a     = addr + 10'(i - 3);
            exp   = 8'h00;
            check = 1'b1;
            if (i == 0) begin
                tx = op;
            end else if (i == 1) begin
                // upper bits of the high address byte are don't care
                tx = {6'($urandom), addr[9:8]};
            end else if (i == 2) begin
                tx = addr[7:0];
            end else if (kind_q[f] == "R") begin
                tx = 8'($urandom);
            end else begin
                tx = data_q.pop_front();
            end
            // dummy byte k returns the register at addr+k
            if (op == OP_READ && i >= 3) begin
                check = written[a];
                exp   = shadow[a];
                assert (check) else begin
                    other_errs++;
                    $display("frame %0d reads address %03h that no earlier frame wrote", f, a);
                end
            end
            shift_byte(tx, half, rx);
            if (op == OP_WRITE && i >= 3) begin
                shadow[a]  = tx;
                written[a] = 1'b1;
            end
            if (check) begin
                assert (rx === exp) else begin
                    value_errs++;
                    $display("[ERROR] %0t ns: frame %0d byte %0d reply %02h, expected %02h",
                             $time, f, i, rx, exp);
                end
            end
        end
        wait_cycles(1);
        spi_cs_i = 1'b1;
        wait_cycles(CS_GAP);
    endtask

    ////////////////////////////////////////////////////////////
    // main sequence and report
    ////////////////////////////////////////////////////////////

    initial begin
        int total;
        int prop_errs;
        rst_i      = 1'b1;
        spi_cs_i   = 1'b1;
        spi_sck_i  = 1'b0;
        spi_mosi_i = 1'b0;
        total      = 0;
        void'($urandom(8));
        for (int i = 0; i < RAM_SIZE; i++) begin
            written[i] = 1'b0;
        end
        load_stimulus();
        foreach (cnt_q[f]) begin
            total += 3 + cnt_q[f];
        end
        cycle_limit = total * 8 * 12 + 200;
        wait_cycles(RST_CYCLES);
        rst_i = 1'b0;
        // miso idles low out of reset
        for (int i = 0; i < 8; i++) begin
            wait_cycles(1);
            assert (spi_miso_o === 1'b0) else begin
                value_errs++;
                $display("[ERROR] %0t ns: miso is %b while idle after reset", $time, spi_miso_o);
            end
        end
        if (other_errs == 0) begin
            foreach (kind_q[f]) begin
                run_frame(f);
            end
        end
        prop_errs = dut_i.rx_fifo_inst.fifo_checks.fail_cnt +
                    dut_i.cmd_engine_inst.engine_checks.fail_cnt;
        $display("errors: %0d reply mismatches, %0d other failures, %0d property failures",
                 value_errs, other_errs, prop_errs);
        if (value_errs == 0 && other_errs == 0 && prop_errs == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb/soc_ctrl_properties.sv ====
// concurrent checks on the receive FIFO and the command engine attached to both by bind
`default_nettype none
`timescale 1ns/1ns

module soc_ctrl_properties (
    input logic clk_i,
    input logic rst_i,
    input logic rd_en_i,
    input logic empty_i,
    input logic wr_en_i,
    input logic full_i,
    input logic pop_i,
    input logic tx_load_i
);

    int fail_cnt = 0;

    // pops only with data present
    read_not_empty: assert property (@(posedge clk_i) disable iff (rst_i)
        rd_en_i |-> !empty_i)
        else begin
            $error("FIFO read while empty");
            fail_cnt++;
        end

    // the receiver never outruns the FIFO
    write_not_full: assert property (@(posedge clk_i) disable iff (rst_i)
        wr_en_i |-> !full_i)
        else begin
            $error("FIFO write while full");
            fail_cnt++;
        end

    // reply load follows a pop by one cycle (registered RAM read)
    load_after_pop: assert property (@(posedge clk_i) disable iff (rst_i)
        tx_load_i |-> $past(pop_i))
        else begin
            $error("tx_load without a pop in the previous cycle");
            fail_cnt++;
        end

endmodule

bind srl_byte_fifo soc_ctrl_properties fifo_checks (
    .clk_i     (clk_250mhz),
    .rst_i     (rst_i),
    .rd_en_i   (rd_o.rd_en),
    .empty_i   (empty),
    .wr_en_i   (wr_en_i),
    .full_i    (full),
    .pop_i     (1'b0),
    .tx_load_i (1'b0)
);

bind soc_cmd_engine soc_ctrl_properties engine_checks (
    .clk_i     (clk_250mhz),
    .rst_i     (rst_i),
    .rd_en_i   (1'b0),
    .empty_i   (1'b0),
    .wr_en_i   (1'b0),
    .full_i    (1'b0),
    .pop_i     (pop),
    .tx_load_i (tx_load_o)
);

`default_nettype wire

// ==== src/soc_ctrl_top.sv ====
// top level of the SPI register control path; the SPI slave feeds the FIFO, then the command engine
`default_nettype none
`timescale 1ns/1ns

module soc_ctrl_top import soc_ctrl_pkg::*; #(
    parameter int FIFO_DEPTH  = DEF_FIFO_DEPTH,
    parameter int SYNC_STAGES = DEF_SYNC_STAGES
) (
    input  logic clk_250mhz,
    input  logic rst_i,
    input  logic spi_cs_i,
    input  logic spi_sck_i,
    input  logic spi_mosi_i,
    output logic spi_miso_o
);

    logic [BYTE_W-1:0] rx_data;
    logic              rx_start;
    logic              rx_valid;
    logic [BYTE_W-1:0] tx_data;
    logic              tx_load;

    rx_byte_if rx_byte ();

    spi_byte_slave #(
        .SYNC_STAGES (SYNC_STAGES)
    ) spi_slave_inst (
        .clk_250mhz  (clk_250mhz),
        .rst_i       (rst_i),
        .spi_cs_i    (spi_cs_i),
        .spi_sck_i   (spi_sck_i),
        .spi_mosi_i  (spi_mosi_i),
        .tx_data_i   (tx_data),
        .tx_load_i   (tx_load),
        .spi_miso_o  (spi_miso_o),
        .rx_data_o   (rx_data),
        .rx_start_o  (rx_start),
        .rx_valid_o  (rx_valid)
    );

    srl_byte_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) rx_fifo_inst (
        .clk_250mhz (clk_250mhz),
        .rst_i      (rst_i),
        .wr_data_i  (rx_data),
        .wr_start_i (rx_start),
        .wr_en_i    (rx_valid),
        .rd_o       (rx_byte.fifo_side)
    );

    soc_cmd_engine cmd_engine_inst (
        .clk_250mhz (clk_250mhz),
        .rst_i      (rst_i),
        .rd_i       (rx_byte.engine_side),
        .tx_data_o  (tx_data),
        .tx_load_o  (tx_load)
    );

endmodule

`default_nettype wire

// ==== src/soc_cmd_engine.sv ====
// command engine; parses SPI frames and reads or writes the 1024 byte register RAM
`default_nettype none
`timescale 1ns/1ns

module soc_cmd_engine import soc_ctrl_pkg::*; (
    input  logic              clk_250mhz,
    input  logic              rst_i,
    rx_byte_if.engine_side    rd_i,
    output logic [BYTE_W-1:0] tx_data_o,
    output logic              tx_load_o
);

    localparam int RAM_DEPTH = 1 << REG_ADDR_W;
    localparam int HI_W      = REG_ADDR_W - BYTE_W;

    // frame stages
    localparam logic [1:0] ST_OPCODE  = 2'd0;
    localparam logic [1:0] ST_ADDR_HI = 2'd1;
    localparam logic [1:0] ST_ADDR_LO = 2'd2;
    localparam logic [1:0] ST_DATA    = 2'd3;

    logic [BYTE_W-1:0]     ram [RAM_DEPTH];
    logic [1:0]            state;
    logic                  is_read;
    logic [HI_W-1:0]       addr_hi;
    logic [REG_ADDR_W-1:0] addr;
    logic [REG_ADDR_W-1:0] next_addr;
    logic [BYTE_W-1:0]     din;
    logic                  sof;
    logic                  pop;
    logic                  body;
    logic                  op_known;
    logic                  addr_step;
    logic                  ram_we;
    logic                  ram_re;

    ////////////////////////////////////////////////////////////
    // decode of the popped byte
    ////////////////////////////////////////////////////////////

    // never stalls the FIFO
    assign pop       = ~rd_i.empty;
    assign rd_i.rd_en = pop;

    assign din       = rd_i.rd_data;
    assign sof       = rd_i.rd_start;
    assign body      = pop & ~sof;
    assign op_known  = (din == OP_WRITE) || (din == OP_READ);
    assign addr_step = body & ((state == ST_ADDR_LO) || (state == ST_DATA));
    assign ram_we    = body & (state == ST_DATA) & ~is_read;
    assign ram_re    = addr_step & is_read;

    // address low byte sets the base, each data byte advances it
    assign next_addr = (state == ST_ADDR_LO) ? {addr_hi, din} : addr + 1'b1;

    ////////////////////////////////////////////////////////////
    // frame FSM
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk_250mhz) begin
        if (rst_i) begin
            state     <= ST_OPCODE;
            is_read   <= 1'b0;
            tx_load_o <= 1'b0;
        end else begin
            tx_load_o <= ram_re;
            if (pop) begin
                if (sof) begin
                    // any frame start restarts the parse
                    is_read <= (din == OP_READ);
                    state   <= op_known ? ST_ADDR_HI : ST_OPCODE;
                end else begin
                    case (state)
                        ST_ADDR_HI: state <= ST_ADDR_LO;
                        ST_ADDR_LO: state <= ST_DATA;
                        // unknown opcode stays here until the next frame
                        default:    state <= state;
                    endcase
                end
            end
        end
    end

    always_ff @(posedge clk_250mhz) begin
        if (body && state == ST_ADDR_HI) begin
            addr_hi <= din[HI_W-1:0];
        end
        if (addr_step) begin
            addr <= next_addr;
        end
    end

    ////////////////////////////////////////////////////////////
    // register RAM
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk_250mhz) begin
        if (ram_we) begin
            ram[addr] <= din;
        end
        if (ram_re) begin
            tx_data_o <= ram[next_addr];
        end
    end

endmodule

`default_nettype wire

// ==== src/srl_byte_fifo.sv ====
// shift-register FIFO between the SPI receiver and the command engine, bytes kept with start flags
`default_nettype none
`timescale 1ns/1ns

module srl_byte_fifo import soc_ctrl_pkg::*; #(
    parameter int FIFO_DEPTH = DEF_FIFO_DEPTH
) (
    input  logic              clk_250mhz,
    input  logic              rst_i,
    input  logic [BYTE_W-1:0] wr_data_i,
    input  logic              wr_start_i,
    input  logic              wr_en_i,
    rx_byte_if.fifo_side      rd_o
);

    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);
    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;

    // start flag sits above the data byte
    logic [BYTE_W:0]  srl [FIFO_DEPTH];
    logic [CNT_W-1:0] count;
    logic [PTR_W-1:0] rd_ptr;
    logic             full;
    logic             empty;
    logic             push;
    logic             pop;

    assign full  = (count == CNT_W'(FIFO_DEPTH));
    assign empty = (count == '0);
    assign push  = wr_en_i & ~full;
    assign pop   = rd_o.rd_en & ~empty;

    // newest entry at index 0, oldest at count-1
    assign rd_ptr = PTR_W'(count - 1'b1);

    assign rd_o.empty = empty;
    assign {rd_o.rd_start, rd_o.rd_data} = srl[rd_ptr];

    always_ff @(posedge clk_250mhz) begin
        if (rst_i) begin
            count <= '0;
        end else if (push && !pop) begin
            count <= count + 1'b1;
        end else if (pop && !push) begin
            count <= count - 1'b1;
        end
    end

    always_ff @(posedge clk_250mhz) begin
        if (push) begin
            srl[0] <= {wr_start_i, wr_data_i};
            for (int i = 1; i < FIFO_DEPTH; i++) begin
                srl[i] <= srl[i-1];
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/spi_byte_slave.sv ====
// SPI mode 0 slave; deserializes mosi into bytes and shifts pending reply bytes out on miso
`default_nettype none
`timescale 1ns/1ns

module spi_byte_slave import soc_ctrl_pkg::*; #(
    parameter int SYNC_STAGES = DEF_SYNC_STAGES
) (
    input  logic              clk_250mhz,
    input  logic              rst_i,
    input  logic              spi_cs_i,
    input  logic              spi_sck_i,
    input  logic              spi_mosi_i,
    input  logic [BYTE_W-1:0] tx_data_i,
    input  logic              tx_load_i,
    output logic              spi_miso_o,
    output logic [BYTE_W-1:0] rx_data_o,
    output logic              rx_start_o,
    output logic              rx_valid_o
);

    localparam int CNT_W = $clog2(BYTE_W);

    // each stage holds cs, sck, mosi in that order
    logic [2:0]        pin_sync [SYNC_STAGES];
    logic              cs_s;
    logic              sck_s;
    logic              mosi_s;
    logic              sck_d;
    logic              sck_rise;
    logic              sck_fall;
    logic              byte_done;
    logic [CNT_W-1:0]  bit_cnt;
    logic              first_byte;
    logic [BYTE_W-1:0] rx_shift;
    logic [BYTE_W-1:0] rx_next;
    logic [BYTE_W-1:0] tx_shift;
    logic [BYTE_W-1:0] pend_data;
    logic              pend_valid;

    ////////////////////////////////////////////////////////////
    // pin synchronizers and sck edge detect
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk_250mhz) begin
        if (rst_i) begin
            for (int i = 0; i < SYNC_STAGES; i++) begin
                pin_sync[i] <= 3'b100;
            end
            sck_d <= 1'b0;
        end else begin
            pin_sync[0] <= {spi_cs_i, spi_sck_i, spi_mosi_i};
            for (int i = 1; i < SYNC_STAGES; i++) begin
                pin_sync[i] <= pin_sync[i-1];
            end
            sck_d <= sck_s;
        end
    end

    assign {cs_s, sck_s, mosi_s} = pin_sync[SYNC_STAGES-1];
    assign sck_rise  = sck_s & ~sck_d;
    assign sck_fall  = ~sck_s & sck_d;
    assign rx_next   = {rx_shift[BYTE_W-2:0], mosi_s};
    assign byte_done = sck_rise & ~cs_s & (bit_cnt == CNT_W'(BYTE_W - 1));

    ////////////////////////////////////////////////////////////
    // bit counter, receive pulse and reply shifter
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk_250mhz) begin
        if (rst_i) begin
            bit_cnt    <= '0;
            first_byte <= 1'b1;
            rx_valid_o <= 1'b0;
            rx_start_o <= 1'b0;
            tx_shift   <= '0;
            pend_valid <= 1'b0;
        end else begin
            rx_valid_o <= byte_done;
            if (cs_s) begin
                // idle between frames, drop any late reply
                bit_cnt    <= '0;
                first_byte <= 1'b1;
                tx_shift   <= '0;
                pend_valid <= 1'b0;
            end else begin
                if (sck_rise) begin
                    bit_cnt <= bit_cnt + 1'b1;
                end
                if (byte_done) begin
                    rx_start_o <= first_byte;
                    first_byte <= 1'b0;
                end
                if (sck_fall) begin
                    // falling edge after the last bit starts the next reply byte
                    if (bit_cnt == '0) begin
                        tx_shift   <= pend_valid ? pend_data : '0;
                        pend_valid <= 1'b0;
                    end else begin
                        tx_shift <= tx_shift << 1;
                    end
                end
                if (tx_load_i) begin
                    pend_valid <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk_250mhz) begin
        if (sck_rise) begin
            rx_shift <= rx_next;
        end
        if (byte_done) begin
            rx_data_o <= rx_next;
        end
        if (tx_load_i) begin
            pend_data <= tx_data_i;
        end
    end

    // msb first
    assign spi_miso_o = tx_shift[BYTE_W-1];

endmodule

`default_nettype wire

// ==== src/rx_byte_if.sv ====
// byte path from the receive FIFO to the command engine; the FIFO shows its oldest entry
`default_nettype none
`timescale 1ns/1ns

interface rx_byte_if import soc_ctrl_pkg::*; ();

    // oldest entry, valid while empty is low
    logic [BYTE_W-1:0] rd_data;
    logic              rd_start;
    logic              empty;

    // pops the oldest entry at the clock edge
    logic              rd_en;

    modport fifo_side (
        output rd_data,
        output rd_start,
        output empty,
        input  rd_en
    );

    modport engine_side (
        input  rd_data,
        input  rd_start,
        input  empty,
        output rd_en
    );

endinterface

`default_nettype wire

// ==== src/soc_ctrl_pkg.sv ====
// protocol opcodes, widths and default sizes shared by the SPI control path modules
`default_nettype none

package soc_ctrl_pkg;

    ////////////////////////////////////////////////////////////
    // SPI byte framing
    ////////////////////////////////////////////////////////////

    localparam int unsigned BYTE_W = 8;

    // first byte of a frame selects the command
    localparam logic [BYTE_W-1:0] OP_WRITE = 8'hB0;
    localparam logic [BYTE_W-1:0] OP_READ  = 8'hA0;

    ////////////////////////////////////////////////////////////
    // register RAM and build defaults
    ////////////////////////////////////////////////////////////

    // 1024 byte register space, high address byte carries the top 2 bits
    localparam int unsigned REG_ADDR_W = 10;

    // receive FIFO depth, must cover bytes in flight to the engine
    localparam int unsigned DEF_FIFO_DEPTH = 16;

    // flops on each SPI pin before edge detection
    localparam int unsigned DEF_SYNC_STAGES = 2;

endpackage

`default_nettype wire
